/* src/accel_defines.svh */
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// Core bus widths
`define ACCEL_ADDR_WIDTH 32
`define ACCEL_DATA_WIDTH 32

// Id width of the accelerator peripheral port
`define ACCEL_ID_WIDTH 8

// Accelerator configuration window in the data address space
`define ACCEL_REGION_START 32'h0010_0000
`define ACCEL_REGION_SIZE 32'h0000_0400

`endif

/* src/bus_pkg.sv */
`default_nettype none

`include "accel_defines.svh"

package bus_pkg;

  // Byte address on the core data and instruction buses
  typedef logic [`ACCEL_ADDR_WIDTH-1:0] addr_t;

  // Read or write data word
  typedef logic [`ACCEL_DATA_WIDTH-1:0] data_t;

  // One enable per data byte
  typedef logic [`ACCEL_DATA_WIDTH/8-1:0] be_t;

  // Transaction id on the peripheral port
  typedef logic [`ACCEL_ID_WIDTH-1:0] id_t;

endpackage

`default_nettype wire

/* src/addr_map_pkg.sv */
`default_nettype none

package addr_map_pkg;

  // Demux target index
  typedef logic [0:0] target_sel_t;

  // Default target for anything outside the accelerator window
  localparam target_sel_t TARGET_EXT = 1'b0;
  // Accelerator configuration port
  localparam target_sel_t TARGET_CFG = 1'b1;

  // One transaction in flight at most
  typedef enum logic {
    DEMUX_IDLE,
    DEMUX_WAIT_RSP
  } demux_state_e;

endpackage

`default_nettype wire

/* src/obi_cut.sv */
`timescale 1ns/1ps
`default_nettype none

module obi_cut #(
  parameter int unsigned PayloadWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Upstream side, facing the requester
  input  logic                    sbr_req_i,
  input  logic [PayloadWidth-1:0] sbr_payload_i,
  output logic                    sbr_gnt_o,
  output logic                    sbr_rvalid_o,
  output bus_pkg::data_t          sbr_rdata_o,
  // Downstream side, facing the target
  output logic                    mgr_req_o,
  output logic [PayloadWidth-1:0] mgr_payload_o,
  input  logic                    mgr_gnt_i,
  input  logic                    mgr_rvalid_i,
  input  bus_pkg::data_t          mgr_rdata_i
);
  import bus_pkg::*;

  logic                    req_valid_q;
  logic [PayloadWidth-1:0] payload_q;
  logic                    rsp_valid_q;
  data_t                   rsp_data_q;
  logic                    accept;

  // Slot is free when empty or when it drains this cycle
  assign sbr_gnt_o = ~req_valid_q | mgr_gnt_i;
  assign accept    = sbr_req_i & sbr_gnt_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (accept) begin
      req_valid_q <= 1'b1;
    end else if (req_valid_q && mgr_gnt_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      payload_q <= sbr_payload_i;
    end
  end

  assign mgr_req_o     = req_valid_q;
  assign mgr_payload_o = payload_q;

  // Response path is a plain one-cycle delay
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= mgr_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mgr_rvalid_i) begin
      rsp_data_q <= mgr_rdata_i;
    end
  end

  assign sbr_rvalid_o = rsp_valid_q;
  assign sbr_rdata_o  = rsp_data_q;

endmodule

`default_nettype wire

/* src/data_demux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

module data_demux (
  input  logic           clk_i,
  input  logic           rst_ni,
  // Core data port
  input  logic           core_req_i,
  input  logic           core_we_i,
  input  bus_pkg::be_t   core_be_i,
  input  bus_pkg::addr_t core_addr_i,
  input  bus_pkg::data_t core_wdata_i,
  output logic           core_gnt_o,
  output logic           core_rvalid_o,
  output bus_pkg::data_t core_rdata_o,
  // External target
  output logic           ext_req_o,
  output logic           ext_we_o,
  output bus_pkg::be_t   ext_be_o,
  output bus_pkg::addr_t ext_addr_o,
  output bus_pkg::data_t ext_wdata_o,
  input  logic           ext_gnt_i,
  input  logic           ext_rvalid_i,
  input  bus_pkg::data_t ext_rdata_i,
  // Configuration target
  output logic           cfg_req_o,
  output logic           cfg_we_o,
  output bus_pkg::be_t   cfg_be_o,
  output bus_pkg::addr_t cfg_addr_o,
  output bus_pkg::data_t cfg_wdata_o,
  input  logic           cfg_gnt_i,
  input  logic           cfg_rvalid_i,
  input  bus_pkg::data_t cfg_rdata_i
);
  import bus_pkg::*;
  import addr_map_pkg::*;

  localparam addr_t RegionStart = addr_t'(`ACCEL_REGION_START);
  localparam addr_t RegionEnd   = addr_t'(`ACCEL_REGION_START + `ACCEL_REGION_SIZE);

  demux_state_e state_q;
  target_sel_t  sel_q;
  target_sel_t  dec_sel;
  logic         idle;
  logic         dec_gnt;
  logic         sel_rvalid;

  // Three rules, only the middle one hits the accelerator
  always_comb begin
    if (core_addr_i < RegionStart) begin
      dec_sel = TARGET_EXT;
    end else if (core_addr_i < RegionEnd) begin
      dec_sel = TARGET_CFG;
    end else begin
      dec_sel = TARGET_EXT;
    end
  end

  assign idle = (state_q == DEMUX_IDLE);

  // Requests only leave while nothing is outstanding
  assign ext_req_o = idle & core_req_i & (dec_sel == TARGET_EXT);
  assign cfg_req_o = idle & core_req_i & (dec_sel == TARGET_CFG);

  // Payload fans out to both sides, req qualifies it
  assign ext_we_o    = core_we_i;
  assign ext_be_o    = core_be_i;
  assign ext_addr_o  = core_addr_i;
  assign ext_wdata_o = core_wdata_i;
  assign cfg_we_o    = core_we_i;
  assign cfg_be_o    = core_be_i;
  assign cfg_addr_o  = core_addr_i;
  assign cfg_wdata_o = core_wdata_i;

  assign dec_gnt    = (dec_sel == TARGET_CFG) ? cfg_gnt_i : ext_gnt_i;
  assign core_gnt_o = idle & core_req_i & dec_gnt;

  // Response steered back from the target that took the request
  assign sel_rvalid    = (sel_q == TARGET_CFG) ? cfg_rvalid_i : ext_rvalid_i;
  assign core_rvalid_o = (state_q == DEMUX_WAIT_RSP) & sel_rvalid;
  assign core_rdata_o  = (sel_q == TARGET_CFG) ? cfg_rdata_i : ext_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DEMUX_IDLE;
      sel_q   <= TARGET_EXT;
    end else begin
      case (state_q)
        DEMUX_IDLE: begin
          if (core_gnt_o) begin
            sel_q   <= dec_sel;
            state_q <= DEMUX_WAIT_RSP;
          end
        end
        DEMUX_WAIT_RSP: begin
          if (core_rvalid_o) begin
            state_q <= DEMUX_IDLE;
          end
        end
        default: state_q <= DEMUX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/accel_complex.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_complex (
  input  logic           clk_i,
  input  logic           rst_ni,
  // Core data port
  input  logic           core_data_req_i,
  input  logic           core_data_we_i,
  input  bus_pkg::be_t   core_data_be_i,
  input  bus_pkg::addr_t core_data_addr_i,
  input  bus_pkg::data_t core_data_wdata_i,
  output logic           core_data_gnt_o,
  output logic           core_data_rvalid_o,
  output bus_pkg::data_t core_data_rdata_o,
  // Core instruction port
  input  logic           core_inst_req_i,
  input  bus_pkg::addr_t core_inst_addr_i,
  output logic           core_inst_gnt_o,
  output logic           core_inst_rvalid_o,
  output bus_pkg::data_t core_inst_rdata_o,
  // External data port
  output logic           ext_data_req_o,
  output logic           ext_data_we_o,
  output bus_pkg::be_t   ext_data_be_o,
  output bus_pkg::addr_t ext_data_addr_o,
  output bus_pkg::data_t ext_data_wdata_o,
  input  logic           ext_data_gnt_i,
  input  logic           ext_data_rvalid_i,
  input  bus_pkg::data_t ext_data_rdata_i,
  // External instruction port
  output logic           ext_inst_req_o,
  output bus_pkg::addr_t ext_inst_addr_o,
  input  logic           ext_inst_gnt_i,
  input  logic           ext_inst_rvalid_i,
  input  bus_pkg::data_t ext_inst_rdata_i,
  // Accelerator configuration port
  output logic           periph_req_o,
  output bus_pkg::addr_t periph_add_o,
  output logic           periph_wen_o,
  output bus_pkg::be_t   periph_be_o,
  output bus_pkg::data_t periph_data_o,
  output bus_pkg::id_t   periph_id_o,
  input  logic           periph_gnt_i,
  input  logic           periph_r_valid_i,
  input  bus_pkg::data_t periph_r_data_i
);
  import bus_pkg::*;

  // Data cut carries we, be, addr and wdata
  localparam int unsigned DataPayloadWidth = 1 + $bits(be_t) + $bits(addr_t) + $bits(data_t);
  localparam int unsigned InstPayloadWidth = $bits(addr_t);

  logic                        dmx_ext_req;
  logic                        dmx_ext_we;
  be_t                         dmx_ext_be;
  addr_t                       dmx_ext_addr;
  data_t                       dmx_ext_wdata;
  logic                        dmx_ext_gnt;
  logic                        dmx_ext_rvalid;
  data_t                       dmx_ext_rdata;
  logic                        cfg_we;
  logic [DataPayloadWidth-1:0] data_payload_up;
  logic [DataPayloadWidth-1:0] data_payload_down;

  data_demux u_data_demux (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_req_i    (core_data_req_i),
    .core_we_i     (core_data_we_i),
    .core_be_i     (core_data_be_i),
    .core_addr_i   (core_data_addr_i),
    .core_wdata_i  (core_data_wdata_i),
    .core_gnt_o    (core_data_gnt_o),
    .core_rvalid_o (core_data_rvalid_o),
    .core_rdata_o  (core_data_rdata_o),
    .ext_req_o     (dmx_ext_req),
    .ext_we_o      (dmx_ext_we),
    .ext_be_o      (dmx_ext_be),
    .ext_addr_o    (dmx_ext_addr),
    .ext_wdata_o   (dmx_ext_wdata),
    .ext_gnt_i     (dmx_ext_gnt),
    .ext_rvalid_i  (dmx_ext_rvalid),
    .ext_rdata_i   (dmx_ext_rdata),
    .cfg_req_o     (periph_req_o),
    .cfg_we_o      (cfg_we),
    .cfg_be_o      (periph_be_o),
    .cfg_addr_o    (periph_add_o),
    .cfg_wdata_o   (periph_data_o),
    .cfg_gnt_i     (periph_gnt_i),
    .cfg_rvalid_i  (periph_r_valid_i),
    .cfg_rdata_i   (periph_r_data_i)
  );

  // Peripheral convention has wen high for reads
  assign periph_wen_o = ~cfg_we;
  assign periph_id_o  = '0;

  assign data_payload_up = {dmx_ext_we, dmx_ext_be, dmx_ext_addr, dmx_ext_wdata};
  assign {ext_data_we_o, ext_data_be_o, ext_data_addr_o, ext_data_wdata_o} = data_payload_down;

  obi_cut #(
    .PayloadWidth (DataPayloadWidth)
  ) u_data_cut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sbr_req_i     (dmx_ext_req),
    .sbr_payload_i (data_payload_up),
    .sbr_gnt_o     (dmx_ext_gnt),
    .sbr_rvalid_o  (dmx_ext_rvalid),
    .sbr_rdata_o   (dmx_ext_rdata),
    .mgr_req_o     (ext_data_req_o),
    .mgr_payload_o (data_payload_down),
    .mgr_gnt_i     (ext_data_gnt_i),
    .mgr_rvalid_i  (ext_data_rvalid_i),
    .mgr_rdata_i   (ext_data_rdata_i)
  );

  // Fetch path has only the address as payload
  obi_cut #(
    .PayloadWidth (InstPayloadWidth)
  ) u_inst_cut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sbr_req_i     (core_inst_req_i),
    .sbr_payload_i (core_inst_addr_i),
    .sbr_gnt_o     (core_inst_gnt_o),
    .sbr_rvalid_o  (core_inst_rvalid_o),
    .sbr_rdata_o   (core_inst_rdata_o),
    .mgr_req_o     (ext_inst_req_o),
    .mgr_payload_o (ext_inst_addr_o),
    .mgr_gnt_i     (ext_inst_gnt_i),
    .mgr_rvalid_i  (ext_inst_rvalid_i),
    .mgr_rdata_i   (ext_inst_rdata_i)
  );

endmodule

`default_nettype wire

/* tests/accel_complex_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

module accel_complex_properties (
  input logic           clk_i,
  input logic           rst_ni,
  input logic           data_gnt_i,
  input logic           data_rvalid_i,
  input logic           ext_data_req_i,
  input logic           ext_data_gnt_i,
  input bus_pkg::addr_t ext_data_addr_i,
  input logic           ext_inst_req_i,
  input logic           ext_inst_gnt_i,
  input bus_pkg::addr_t ext_inst_addr_i,
  input logic           periph_req_i,
  input logic           periph_gnt_i,
  input bus_pkg::addr_t periph_addr_i
);
  import bus_pkg::*;

  localparam addr_t RegionStart = `ACCEL_REGION_START;
  localparam addr_t RegionEnd   = `ACCEL_REGION_START + `ACCEL_REGION_SIZE;

  logic rsp_pending_q;

  // Tracks the one data transaction the demux may have in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_pending_q <= 1'b0;
    end else if (data_gnt_i) begin
      rsp_pending_q <= 1'b1;
    end else if (data_rvalid_i) begin
      rsp_pending_q <= 1'b0;
    end
  end

  single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_pending_q |-> !data_gnt_i)
    else $error("data grant while a response is pending");

  periph_in_region: assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_req_i |-> (periph_addr_i >= RegionStart) && (periph_addr_i < RegionEnd))
    else $error("configuration request outside the accelerator region");

  ext_data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ext_data_req_i && !ext_data_gnt_i |=> ext_data_req_i && $stable(ext_data_addr_i))
    else $error("external data request dropped or changed before grant");

  ext_inst_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ext_inst_req_i && !ext_inst_gnt_i |=> ext_inst_req_i && $stable(ext_inst_addr_i))
    else $error("instruction request dropped or changed before grant");

  periph_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_req_i && !periph_gnt_i |=> periph_req_i && $stable(periph_addr_i))
    else $error("configuration request dropped or changed before grant");

  // Nothing may leave the complex in the first cycle out of reset
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !ext_data_req_i && !ext_inst_req_i && !periph_req_i)
    else $error("request output high right after reset");

endmodule

`default_nettype wire

/* tests/tb_accel_complex.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

// Target model with a random grant delay and a single-cycle response
module bus_responder #(
  parameter logic [31:0] Seed = 32'h1
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  bus_pkg::data_t rsp_data_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output bus_pkg::data_t rdata_o
);
  import bus_pkg::*;

  logic [31:0] lcg_state = Seed;
  logic [1:0]  wait_cnt  = 2'd0;
  logic        waiting   = 1'b0;
  logic        gnt_q     = 1'b0;
  logic        rvalid_q  = 1'b0;
  data_t       rdata_q   = '0;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lcg_state <= Seed;
      waiting   <= 1'b0;
      gnt_q     <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      if (req_i && gnt_q) begin
        // Transfer happened, answer in the next cycle
        gnt_q    <= 1'b0;
        rvalid_q <= 1'b1;
        rdata_q  <= rsp_data_i;
      end else if (req_i && !waiting) begin
        lcg_state <= lcg_step(lcg_state);
        if (lcg_state[29:28] == 2'd0) begin
          gnt_q <= 1'b1;
        end else begin
          wait_cnt <= lcg_state[29:28] - 2'd1;
          waiting  <= 1'b1;
        end
      end else if (req_i && waiting) begin
        if (wait_cnt == 2'd0) begin
          gnt_q   <= 1'b1;
          waiting <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

  assign gnt_o    = gnt_q;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

module tb_accel_complex;
  import bus_pkg::*;

  localparam int NumPatterns   = 20;
  localparam int PatternFields = 6;
  localparam int TimeoutCycles = 20 * NumPatterns + 100;
  localparam logic [31:0] LcgSeed = 32'h8f6c00c8;
  localparam addr_t RegionStart = `ACCEL_REGION_START;
  localparam addr_t RegionEnd   = `ACCEL_REGION_START + `ACCEL_REGION_SIZE;

  logic [31:0] pattern_words [NumPatterns*PatternFields];

  logic  clk_i;
  logic  rst_ni;
  logic  core_data_req_i;
  logic  core_data_we_i;
  be_t   core_data_be_i;
  addr_t core_data_addr_i;
  data_t core_data_wdata_i;
  logic  core_data_gnt_o;
  logic  core_data_rvalid_o;
  data_t core_data_rdata_o;
  logic  core_inst_req_i;
  addr_t core_inst_addr_i;
  logic  core_inst_gnt_o;
  logic  core_inst_rvalid_o;
  data_t core_inst_rdata_o;
  logic  ext_data_req_o;
  logic  ext_data_we_o;
  be_t   ext_data_be_o;
  addr_t ext_data_addr_o;
  data_t ext_data_wdata_o;
  logic  ext_data_gnt_i;
  logic  ext_data_rvalid_i;
  data_t ext_data_rdata_i;
  logic  ext_inst_req_o;
  addr_t ext_inst_addr_o;
  logic  ext_inst_gnt_i;
  logic  ext_inst_rvalid_i;
  data_t ext_inst_rdata_i;
  logic  periph_req_o;
  addr_t periph_add_o;
  logic  periph_wen_o;
  be_t   periph_be_o;
  data_t periph_data_o;
  id_t   periph_id_o;
  logic  periph_gnt_i;
  logic  periph_r_valid_i;
  data_t periph_r_data_i;

  // Responder data of the access in progress
  data_t rsp_word = '0;

  // What the targets saw at their request handshake
  int    cycle_cnt       = 0;
  int    ext_data_cnt    = 0;
  int    inst_cnt        = 0;
  int    cfg_cnt         = 0;
  int    data_rvalid_cnt = 0;
  int    inst_rvalid_cnt = 0;
  logic  seen_ext_we;
  be_t   seen_ext_be;
  addr_t seen_ext_addr;
  data_t seen_ext_wdata;
  addr_t seen_inst_addr;
  logic  seen_cfg_wen;
  be_t   seen_cfg_be;
  addr_t seen_cfg_addr;
  data_t seen_cfg_wdata;
  id_t   seen_cfg_id;

  accel_complex DUT (.*);

  bind accel_complex accel_complex_properties u_properties (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_gnt_i      (core_data_gnt_o),
    .data_rvalid_i   (core_data_rvalid_o),
    .ext_data_req_i  (ext_data_req_o),
    .ext_data_gnt_i  (ext_data_gnt_i),
    .ext_data_addr_i (ext_data_addr_o),
    .ext_inst_req_i  (ext_inst_req_o),
    .ext_inst_gnt_i  (ext_inst_gnt_i),
    .ext_inst_addr_i (ext_inst_addr_o),
    .periph_req_i    (periph_req_o),
    .periph_gnt_i    (periph_gnt_i),
    .periph_addr_i   (periph_add_o)
  );

  bus_responder #(
    .Seed (LcgSeed)
  ) u_ext_data_rsp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ext_data_req_o),
    .rsp_data_i (rsp_word),
    .gnt_o      (ext_data_gnt_i),
    .rvalid_o   (ext_data_rvalid_i),
    .rdata_o    (ext_data_rdata_i)
  );

  bus_responder #(
    .Seed (LcgSeed)
  ) u_ext_inst_rsp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ext_inst_req_o),
    .rsp_data_i (rsp_word),
    .gnt_o      (ext_inst_gnt_i),
    .rvalid_o   (ext_inst_rvalid_i),
    .rdata_o    (ext_inst_rdata_i)
  );

  bus_responder #(
    .Seed (LcgSeed)
  ) u_periph_rsp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (periph_req_o),
    .rsp_data_i (rsp_word),
    .gnt_o      (periph_gnt_i),
    .rvalid_o   (periph_r_valid_i),
    .rdata_o    (periph_r_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: no result after %0d clock cycles", TimeoutCycles);
      $display("Verification failed");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // Record every handshake on the target side and every response on the core side
  always @(posedge clk_i) begin
    if (ext_data_req_o && ext_data_gnt_i) begin
      ext_data_cnt   <= ext_data_cnt + 1;
      seen_ext_we    <= ext_data_we_o;
      seen_ext_be    <= ext_data_be_o;
      seen_ext_addr  <= ext_data_addr_o;
      seen_ext_wdata <= ext_data_wdata_o;
    end
    if (ext_inst_req_o && ext_inst_gnt_i) begin
      inst_cnt       <= inst_cnt + 1;
      seen_inst_addr <= ext_inst_addr_o;
    end
    if (periph_req_o && periph_gnt_i) begin
      cfg_cnt        <= cfg_cnt + 1;
      seen_cfg_wen   <= periph_wen_o;
      seen_cfg_be    <= periph_be_o;
      seen_cfg_addr  <= periph_add_o;
      seen_cfg_wdata <= periph_data_o;
      seen_cfg_id    <= periph_id_o;
    end
    if (core_data_rvalid_o) begin
      data_rvalid_cnt <= data_rvalid_cnt + 1;
    end
    if (core_inst_rvalid_o) begin
      inst_rvalid_cnt <= inst_rvalid_cnt + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic access_data(input int idx, input logic we, input be_t be,
                             input addr_t addr, input data_t wdata, input data_t rsp);
    int   ext_before;
    int   cfg_before;
    int   nxt;
    logic in_region;
    ext_before = ext_data_cnt;
    cfg_before = cfg_cnt;
    nxt        = (idx + 1) * PatternFields;
    in_region  = (addr >= RegionStart) && (addr < RegionEnd);
    rsp_word          <= rsp;
    core_data_req_i   <= 1'b1;
    core_data_we_i    <= we;
    core_data_be_i    <= be;
    core_data_addr_i  <= addr;
    core_data_wdata_i <= wdata;
    do begin
      @(posedge clk_i);
    end while (!core_data_gnt_o);
    // A following data access is offered while this one is still in flight
    if ((idx + 1 < NumPatterns) && (pattern_words[nxt] == 32'd0)) begin
      core_data_we_i    <= pattern_words[nxt+1][0];
      core_data_be_i    <= pattern_words[nxt+2][3:0];
      core_data_addr_i  <= pattern_words[nxt+3];
      core_data_wdata_i <= pattern_words[nxt+4];
    end else begin
      core_data_req_i <= 1'b0;
    end
    do begin
      @(posedge clk_i);
    end while (!core_data_rvalid_o);
    if (!we) begin
      check_value($sformatf("p%0d data_rdata", idx), rsp, core_data_rdata_o);
    end
    if (in_region) begin
      check_value($sformatf("p%0d cfg_count", idx), 32'(cfg_before + 1), 32'(cfg_cnt));
      check_value($sformatf("p%0d ext_count", idx), 32'(ext_before), 32'(ext_data_cnt));
      check_value($sformatf("p%0d cfg_wen", idx), 32'(!we), 32'(seen_cfg_wen));
      check_value($sformatf("p%0d cfg_be", idx), 32'(be), 32'(seen_cfg_be));
      check_value($sformatf("p%0d cfg_addr", idx), addr, seen_cfg_addr);
      check_value($sformatf("p%0d cfg_wdata", idx), wdata, seen_cfg_wdata);
      check_value($sformatf("p%0d cfg_id", idx), 32'd0, 32'(seen_cfg_id));
    end else begin
      check_value($sformatf("p%0d ext_count", idx), 32'(ext_before + 1), 32'(ext_data_cnt));
      check_value($sformatf("p%0d cfg_count", idx), 32'(cfg_before), 32'(cfg_cnt));
      check_value($sformatf("p%0d ext_we", idx), 32'(we), 32'(seen_ext_we));
      check_value($sformatf("p%0d ext_be", idx), 32'(be), 32'(seen_ext_be));
      check_value($sformatf("p%0d ext_addr", idx), addr, seen_ext_addr);
      check_value($sformatf("p%0d ext_wdata", idx), wdata, seen_ext_wdata);
    end
  endtask

  task automatic fetch_inst(input int idx, input addr_t addr, input data_t rsp);
    int inst_before;
    inst_before = inst_cnt;
    rsp_word         <= rsp;
    core_inst_req_i  <= 1'b1;
    core_inst_addr_i <= addr;
    do begin
      @(posedge clk_i);
    end while (!core_inst_gnt_o);
    core_inst_req_i <= 1'b0;
    do begin
      @(posedge clk_i);
    end while (!core_inst_rvalid_o);
    check_value($sformatf("p%0d inst_rdata", idx), rsp, core_inst_rdata_o);
    check_value($sformatf("p%0d inst_count", idx), 32'(inst_before + 1), 32'(inst_cnt));
    check_value($sformatf("p%0d inst_addr", idx), addr, seen_inst_addr);
  endtask

  initial begin
    int base;
    int data_total;
    int inst_total;
    data_total = 0;
    inst_total = 0;
    rst_ni            = 1'b0;
    core_data_req_i   = 1'b0;
    core_data_we_i    = 1'b0;
    core_data_be_i    = '0;
    core_data_addr_i  = '0;
    core_data_wdata_i = '0;
    core_inst_req_i   = 1'b0;
    core_inst_addr_i  = '0;
    $readmemh("tests/accel_patterns.mem", pattern_words);
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      check_value("reset_outputs_low", 32'd0, 32'({ext_data_req_o, ext_inst_req_o,
                  periph_req_o, core_data_rvalid_o, core_inst_rvalid_o}));
    end
    for (int idx = 0; idx < NumPatterns; idx++) begin
      base = idx * PatternFields;
      if (pattern_words[base] == 32'd0) begin
        data_total = data_total + 1;
        access_data(idx, pattern_words[base+1][0], pattern_words[base+2][3:0],
                    pattern_words[base+3], pattern_words[base+4], pattern_words[base+5]);
      end else begin
        inst_total = inst_total + 1;
        fetch_inst(idx, pattern_words[base+3], pattern_words[base+5]);
      end
    end
    // Late or duplicate responses would show up here
    repeat (10) @(posedge clk_i);
    check_value("data_rvalid_total", 32'(data_total), 32'(data_rvalid_cnt));
    check_value("inst_rvalid_total", 32'(inst_total), 32'(inst_rvalid_cnt));
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/accel_patterns.mem */
// port(0 data, 1 fetch) write be address wdata rsp_data
// region 00100000 to 001003ff goes to the configuration port
0 1 f 000ffffc 11111111 00000000
0 0 f 000ffffc 00000000 a5a5a5a5
0 1 f 00100000 22222222 00000000
0 0 f 00100000 00000000 5a5a5a5a
0 1 3 001003fc 33334444 00000000
0 0 f 001003fc 00000000 c0ffee01
0 1 c 00100400 55556666 00000000
0 0 f 00100400 00000000 0badf00d
1 0 0 00000080 00000000 00000013
1 0 0 00000084 00000000 00a00093
0 0 f 00000010 00000000 12345678
0 1 1 80000000 deadbeef 00000000
0 0 f fffffffc 00000000 9abcdef0
0 1 f 00100200 cafef00d 00000000
0 0 f 00100200 00000000 87654321
1 0 0 00000088 00000000 00b00113
0 1 8 20000004 a1b2c3d4 00000000
0 0 f 00100104 00000000 13572468
1 0 0 0000008c 00000000 0000006f
0 0 f 00000000 00000000 fedcba98

/* project.f */
+incdir+src
src/bus_pkg.sv
src/addr_map_pkg.sv
src/obi_cut.sv
src/data_demux.sv
src/accel_complex.sv
tests/accel_complex_properties.sv
tests/tb_accel_complex.sv

/* Makefile */
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tb_accel_complex
FILELIST  ?= project.f

BIN     := obj_dir/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)
LOG     := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
